//--- common/fir_defs.svh
// widths, depths, tap count and register map of the FIR block
// include wherever a macro below is needed; the guard makes repeats harmless

`ifndef FIR_DEFS_SVH
`define FIR_DEFS_SVH

// sample, coefficient and bus data width
`define FIR_DATA_W       32
// AXI-Lite address width
`define FIR_ADDR_W       12
`define FIR_NUM_TAPS     11
// entries in each stream FIFO
`define FIR_FIFO_DEPTH   16

// register offsets
`define FIR_REG_CTRL     12'h000
`define FIR_REG_LEN      12'h010
`define FIR_REG_TAP_BASE 12'h040

// control register bit positions
`define FIR_CTRL_START   0
`define FIR_CTRL_DONE    1
`define FIR_CTRL_IDLE    2
`define FIR_CTRL_READY   4

`endif

//--- common/fir_pkg.sv
// shared types of the FIR block: engine states and data words
// modules import it inside their body and use scoped names in port lists

`default_nettype none

`include "fir_defs.svh"

package fir_pkg;

    // engine sequencing
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_MAC,
        ST_PUSH
    } fir_state_e;

    typedef logic signed [`FIR_DATA_W-1:0] data_t;
    typedef logic [`FIR_ADDR_W-1:0] addr_t;
    // tap number or history slot
    typedef logic [3:0] tap_idx_t;

endpackage

`default_nettype wire

//--- fir/word_ram.sv
// single-port word RAM, registered read with one cycle of latency
// holds the coefficients and the sample history

`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 11
) (
    input  wire logic                     axis_clk,
    input  wire logic                     we_i,
    input  wire logic [$clog2(DEPTH)-1:0] addr_i,
    input  wire logic [WIDTH-1:0]         wdata_i,
    output logic [WIDTH-1:0]              rdata_o
);
    logic [WIDTH-1:0] mem [DEPTH];

    // read returns the old word when written in the same cycle
    always_ff @(posedge axis_clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- hdl/stream_fifo.sv
// synchronous FIFO with valid/ready on both sides
// out_data_o shows the head entry whenever out_valid_o is high

`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  wire logic             axis_clk,
    input  wire logic             axis_rst_n,
    input  wire logic             in_valid_i,
    input  wire logic [WIDTH-1:0] in_data_i,
    output logic                  in_ready_o,
    output logic                  out_valid_o,
    output logic [WIDTH-1:0]      out_data_o,
    input  wire logic             out_ready_i
);
    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    // extra msb tells full from empty
    logic [AW:0]      wr_ptr;
    logic [AW:0]      rd_ptr;
    logic             push;
    logic             pop;

    assign out_valid_o = (wr_ptr != rd_ptr);
    assign in_ready_o  = !((wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]));
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;
    assign out_data_o  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= in_data_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fir_regs.sv
// AXI-Lite register block: control bits, data length and coefficient RAM
// hands start/len to the engine and shares the coefficient RAM with it

`timescale 1ns/1ps
`default_nettype none

`include "fir_defs.svh"

module fir_regs (
    input  wire logic               axis_clk,
    input  wire logic               axis_rst_n,
    input  wire logic               awvalid_i,
    input  wire fir_pkg::addr_t     awaddr_i,
    output logic                    awready_o,
    input  wire logic               wvalid_i,
    input  wire fir_pkg::data_t     wdata_i,
    output logic                    wready_o,
    input  wire logic               arvalid_i,
    input  wire fir_pkg::addr_t     araddr_i,
    output logic                    arready_o,
    output logic                    rvalid_o,
    output fir_pkg::data_t          rdata_o,
    input  wire logic               rready_i,
    input  wire logic               ss_ready_i,
    output logic                    start_o,
    input  wire logic               busy_i,
    input  wire logic               done_i,
    output fir_pkg::data_t          len_o,
    input  wire fir_pkg::tap_idx_t  tap_idx_i,
    output fir_pkg::data_t          tap_coef_o
);
    import fir_pkg::*;

    logic     aw_held;
    logic     w_held;
    logic     wr_en;
    addr_t    wr_addr_q;
    data_t    wr_data_q;
    logic     rd_s1;
    addr_t    rd_addr_q;
    data_t    rd_val;
    data_t    ctrl_val;
    logic     ap_start;
    logic     ap_done;
    logic     run_active;
    logic     tap_we;
    tap_idx_t tap_addr;

    // word-aligned offset inside the coefficient window
    function automatic logic is_tap(addr_t a);
        return (a >= `FIR_REG_TAP_BASE) &&
               (a < `FIR_REG_TAP_BASE + 12'(4 * `FIR_NUM_TAPS)) &&
               (a[1:0] == 2'b00);
    endfunction

    function automatic tap_idx_t tap_of(addr_t a);
        addr_t off;
        off = a - `FIR_REG_TAP_BASE;
        return is_tap(a) ? off[5:2] : '0;
    endfunction

    assign wr_en      = aw_held && w_held;
    assign awready_o  = !aw_held;
    assign wready_o   = !w_held;
    assign arready_o  = !rd_s1 && !rvalid_o && !wr_en;
    assign run_active = ap_start || busy_i;
    assign tap_we     = wr_en && !run_active && is_tap(wr_addr_q);

    // engine owns the RAM address for the whole run
    always_comb begin
        if (busy_i) begin
            tap_addr = tap_idx_i;
        end else if (wr_en) begin
            tap_addr = tap_of(wr_addr_q);
        end else begin
            tap_addr = tap_of(araddr_i);
        end
    end

    always_comb begin
        ctrl_val = '0;
        ctrl_val[`FIR_CTRL_START] = ap_start;
        ctrl_val[`FIR_CTRL_DONE]  = ap_done;
        ctrl_val[`FIR_CTRL_IDLE]  = !run_active;
        ctrl_val[`FIR_CTRL_READY] = ss_ready_i;
        if (rd_addr_q == `FIR_REG_CTRL) begin
            rd_val = ctrl_val;
        end else if (rd_addr_q == `FIR_REG_LEN) begin
            rd_val = len_o;
        end else if (is_tap(rd_addr_q) && !run_active) begin
            rd_val = tap_coef_o;
        end else begin
            rd_val = '0;
        end
    end

    // address and data channels are captured independently
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else if (wr_en) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            if (awvalid_i && awready_o) begin
                aw_held <= 1'b1;
            end
            if (wvalid_i && wready_o) begin
                w_held <= 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (awvalid_i && awready_o) begin
            wr_addr_q <= awaddr_i;
        end
        if (wvalid_i && wready_o) begin
            wr_data_q <= wdata_i;
        end
        if (arvalid_i && arready_o) begin
            rd_addr_q <= araddr_i;
        end
        // stage 2 of the read, RAM output is valid now
        if (rd_s1) begin
            rdata_o <= rd_val;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            start_o  <= 1'b0;
            len_o    <= '0;
            rd_s1    <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (wr_en && !run_active) begin
                if (wr_addr_q == `FIR_REG_CTRL && wr_data_q[`FIR_CTRL_START]) begin
                    ap_start <= 1'b1;
                    start_o  <= 1'b1;
                end
                if (wr_addr_q == `FIR_REG_LEN) begin
                    len_o <= wr_data_q;
                end
            end
            // first sample taken
            if (busy_i) begin
                ap_start <= 1'b0;
            end
            if (done_i) begin
                ap_done <= 1'b1;
            end else if (rd_s1 && rd_addr_q == `FIR_REG_CTRL) begin
                ap_done <= 1'b0;
            end
            rd_s1 <= arvalid_i && arready_o;
            if (rd_s1) begin
                rvalid_o <= 1'b1;
            end else if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    word_ram #(.WIDTH(`FIR_DATA_W), .DEPTH(`FIR_NUM_TAPS)) u_tap_ram (
        .axis_clk (axis_clk),
        .we_i     (tap_we),
        .addr_i   (tap_addr),
        .wdata_i  (wr_data_q),
        .rdata_o  (tap_coef_o)
    );

endmodule

`default_nettype wire

//--- fir/fir_engine.sv
// FIR processing engine: pops a sample, runs one MAC step per tap, pushes the result
// the sample history lives in a circular RAM of the last taps-many samples

`timescale 1ns/1ps
`default_nettype none

`include "fir_defs.svh"

module fir_engine (
    input  wire logic              axis_clk,
    input  wire logic              axis_rst_n,
    input  wire logic              start_i,
    output logic                   busy_o,
    output logic                   done_o,
    input  wire fir_pkg::data_t    len_i,
    output fir_pkg::tap_idx_t      tap_idx_o,
    input  wire fir_pkg::data_t    tap_coef_i,
    input  wire logic              smp_valid_i,
    input  wire fir_pkg::data_t    smp_data_i,
    output logic                   smp_pop_o,
    input  wire logic              res_full_i,
    output fir_pkg::data_t         res_data_o,
    output logic                   res_last_o,
    output logic                   res_push_o
);
    import fir_pkg::*;

    localparam tap_idx_t LAST_SLOT = tap_idx_t'(`FIR_NUM_TAPS - 1);
    localparam tap_idx_t MAC_END   = tap_idx_t'(`FIR_NUM_TAPS);

    fir_state_e             state;
    tap_idx_t               step;
    tap_idx_t               wr_ptr;
    tap_idx_t               rd_ptr;
    tap_idx_t               hist_addr;
    logic [`FIR_DATA_W-1:0] run_cnt;
    logic                   acc_en_q;
    logic                   hist_ok_q;
    data_t                  hist_rdata;
    data_t                  prod;
    data_t                  acc;

    assign smp_pop_o  = (state == ST_WAIT) && smp_valid_i;
    assign res_push_o = (state == ST_PUSH) && !res_full_i;
    // run_cnt already counts the sample behind this result
    assign res_last_o = (run_cnt == $unsigned(len_i));
    assign done_o     = res_push_o && res_last_o;
    assign res_data_o = acc;
    assign busy_o     = (state == ST_MAC) || (state == ST_PUSH) ||
                        ((state == ST_WAIT) && (run_cnt != '0));

    // coefficient k and sample n-k are addressed in the same cycle
    assign tap_idx_o  = ((state == ST_MAC) && (step != MAC_END)) ? step : '0;
    assign hist_addr  = smp_pop_o ? wr_ptr : rd_ptr;
    // 32-bit wrapping product
    assign prod       = hist_rdata * tap_coef_i;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= ST_IDLE;
            step      <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            run_cnt   <= '0;
            acc_en_q  <= 1'b0;
            hist_ok_q <= 1'b0;
        end else begin
            // delayed by one to line up with the RAM outputs
            acc_en_q  <= (state == ST_MAC) && (step != MAC_END);
            hist_ok_q <= (32'(step) < run_cnt);
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        state   <= ST_WAIT;
                        wr_ptr  <= '0;
                        run_cnt <= '0;
                    end
                end
                ST_WAIT: begin
                    if (smp_valid_i) begin
                        state   <= ST_MAC;
                        step    <= '0;
                        rd_ptr  <= wr_ptr;
                        wr_ptr  <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
                        run_cnt <= run_cnt + 1'b1;
                    end
                end
                ST_MAC: begin
                    step   <= step + 1'b1;
                    // walk back towards older samples
                    rd_ptr <= (rd_ptr == '0) ? LAST_SLOT : rd_ptr - 1'b1;
                    if (step == MAC_END) begin
                        state <= ST_PUSH;
                    end
                end
                ST_PUSH: begin
                    // hold the result until the output FIFO has room
                    if (!res_full_i) begin
                        state <= res_last_o ? ST_IDLE : ST_WAIT;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // slots older than the run count as zero samples
    always_ff @(posedge axis_clk) begin
        if (smp_pop_o) begin
            acc <= '0;
        end else if (acc_en_q && hist_ok_q) begin
            acc <= acc + prod;
        end
    end

    word_ram #(.WIDTH(`FIR_DATA_W), .DEPTH(`FIR_NUM_TAPS)) u_hist_ram (
        .axis_clk (axis_clk),
        .we_i     (smp_pop_o),
        .addr_i   (hist_addr),
        .wdata_i  (smp_data_i),
        .rdata_o  (hist_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/fir_top.sv
// top level of the FIR filter: AXI-Lite registers, stream FIFOs and MAC engine
// samples enter on ss_*, results leave on sm_* with tlast on the final one

`timescale 1ns/1ps
`default_nettype none

`include "fir_defs.svh"

module fir_top (
    input  wire logic             axis_clk,
    input  wire logic             axis_rst_n,
    // AXI-Lite
    input  wire logic             awvalid_i,
    input  wire fir_pkg::addr_t   awaddr_i,
    output wire logic             awready_o,
    input  wire logic             wvalid_i,
    input  wire fir_pkg::data_t   wdata_i,
    output wire logic             wready_o,
    input  wire logic             arvalid_i,
    input  wire fir_pkg::addr_t   araddr_i,
    output wire logic             arready_o,
    output wire logic             rvalid_o,
    output wire fir_pkg::data_t   rdata_o,
    input  wire logic             rready_i,
    // input stream
    input  wire logic             ss_tvalid_i,
    input  wire fir_pkg::data_t   ss_tdata_i,
    output wire logic             ss_tready_o,
    // output stream
    output wire logic             sm_tvalid_o,
    output wire fir_pkg::data_t   sm_tdata_o,
    output wire logic             sm_tlast_o,
    input  wire logic             sm_tready_i
);
    import fir_pkg::*;

    logic     start;
    logic     busy;
    logic     done;
    data_t    len;
    tap_idx_t tap_idx;
    data_t    tap_coef;
    logic     smp_valid;
    data_t    smp_data;
    logic     smp_pop;
    data_t    res_data;
    logic     res_last;
    logic     res_push;
    logic     res_ready;

    fir_regs u_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid_i  (awvalid_i),
        .awaddr_i   (awaddr_i),
        .awready_o  (awready_o),
        .wvalid_i   (wvalid_i),
        .wdata_i    (wdata_i),
        .wready_o   (wready_o),
        .arvalid_i  (arvalid_i),
        .araddr_i   (araddr_i),
        .arready_o  (arready_o),
        .rvalid_o   (rvalid_o),
        .rdata_o    (rdata_o),
        .rready_i   (rready_i),
        .ss_ready_i (ss_tready_o),
        .start_o    (start),
        .busy_i     (busy),
        .done_i     (done),
        .len_o      (len),
        .tap_idx_i  (tap_idx),
        .tap_coef_o (tap_coef)
    );

    stream_fifo #(.WIDTH(`FIR_DATA_W), .DEPTH(`FIR_FIFO_DEPTH)) u_in_fifo (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .in_valid_i  (ss_tvalid_i),
        .in_data_i   (ss_tdata_i),
        .in_ready_o  (ss_tready_o),
        .out_valid_o (smp_valid),
        .out_data_o  (smp_data),
        .out_ready_i (smp_pop)
    );

    fir_engine u_engine (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .start_i     (start),
        .busy_o      (busy),
        .done_o      (done),
        .len_i       (len),
        .tap_idx_o   (tap_idx),
        .tap_coef_i  (tap_coef),
        .smp_valid_i (smp_valid),
        .smp_data_i  (smp_data),
        .smp_pop_o   (smp_pop),
        .res_full_i  (!res_ready),
        .res_data_o  (res_data),
        .res_last_o  (res_last),
        .res_push_o  (res_push)
    );

    // entry is {last, data}
    stream_fifo #(.WIDTH(`FIR_DATA_W + 1), .DEPTH(`FIR_FIFO_DEPTH)) u_out_fifo (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .in_valid_i  (res_push),
        .in_data_i   ({res_last, res_data}),
        .in_ready_o  (res_ready),
        .out_valid_o (sm_tvalid_o),
        .out_data_o  ({sm_tlast_o, sm_tdata_o}),
        .out_ready_i (sm_tready_i)
    );

endmodule

`default_nettype wire

//--- tests/fir_properties.sv
// concurrent checks on the FIR top-level ports
// bound into fir_top, reports only through failing assertions

`timescale 1ns/1ps
`default_nettype none

module fir_properties (
    input wire logic            axis_clk,
    input wire logic            axis_rst_n,
    input wire logic            arvalid_i,
    input wire logic            arready_o,
    input wire logic            rvalid_o,
    input wire fir_pkg::data_t  rdata_o,
    input wire logic            rready_i,
    input wire logic            sm_tvalid_o,
    input wire fir_pkg::data_t  sm_tdata_o,
    input wire logic            sm_tlast_o,
    input wire logic            sm_tready_i
);

    // read data shows up exactly two cycles after the address handshake
    read_latency: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        $past(arvalid_i && arready_o, 2) |-> rvalid_o && !$past(rvalid_o))
        else $error("read data not valid two cycles after the read address");

    read_no_stray: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid_o && !$past(rvalid_o) |-> $past(arvalid_i && arready_o, 2))
        else $error("read data valid without a read address two cycles before");

    read_held: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        $past(rvalid_o && !rready_i) |-> rvalid_o && $stable(rdata_o))
        else $error("read data dropped or changed before it was accepted");

    // stalled output keeps its head entry
    out_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        $past(sm_tvalid_o && !sm_tready_i) |->
            sm_tvalid_o && $stable(sm_tdata_o) && $stable(sm_tlast_o))
        else $error("output stream changed while stalled");

endmodule

bind fir_top fir_properties u_props (
    .axis_clk    (axis_clk),
    .axis_rst_n  (axis_rst_n),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .rready_i    (rready_i),
    .sm_tvalid_o (sm_tvalid_o),
    .sm_tdata_o  (sm_tdata_o),
    .sm_tlast_o  (sm_tlast_o),
    .sm_tready_i (sm_tready_i)
);

`default_nettype wire

//--- tests/fir_tb.sv
// testbench for the FIR filter top level
// programs taps and length over AXI-Lite, streams two runs, checks results against a model

`timescale 1ns/1ps
`default_nettype none

`include "fir_defs.svh"

module fir_tb;
    import fir_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RUN1_LEN     = 40;
    localparam int RUN2_LEN     = 25;
    localparam int STALL_CYCLES = 300;
    // per-sample engine time with margin, plus register traffic and the long stall
    localparam int WATCHDOG_CYCLES =
        (RUN1_LEN + RUN2_LEN) * (`FIR_NUM_TAPS + 4) * 4 + STALL_CYCLES + 3000;

    logic        axis_clk;
    logic        axis_rst_n;
    logic        awvalid;
    addr_t       awaddr;
    logic        awready;
    logic        wvalid;
    data_t       wdata;
    logic        wready;
    logic        arvalid;
    addr_t       araddr;
    logic        arready;
    logic        rvalid;
    data_t       rdata;
    logic        rready;
    logic        ss_tvalid;
    data_t       ss_tdata;
    logic        ss_tready;
    logic        sm_tvalid;
    data_t       sm_tdata;
    logic        sm_tlast;
    logic        sm_tready;

    data_t       coef [`FIR_NUM_TAPS];
    data_t       samples [64];
    data_t       expected [64];
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          sent;
    logic        saw_backpressure;

    fir_top u_dut (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid_i   (awvalid),
        .awaddr_i    (awaddr),
        .awready_o   (awready),
        .wvalid_i    (wvalid),
        .wdata_i     (wdata),
        .wready_o    (wready),
        .arvalid_i   (arvalid),
        .araddr_i    (araddr),
        .arready_o   (arready),
        .rvalid_o    (rvalid),
        .rdata_o     (rdata),
        .rready_i    (rready),
        .ss_tvalid_i (ss_tvalid),
        .ss_tdata_i  (ss_tdata),
        .ss_tready_o (ss_tready),
        .sm_tvalid_o (sm_tvalid),
        .sm_tdata_o  (sm_tdata),
        .sm_tlast_o  (sm_tlast),
        .sm_tready_i (sm_tready)
    );

    initial axis_clk = 1'b0;
    always #(CLK_PERIOD / 2) axis_clk = ~axis_clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // all tasks start and end 10 ns after a rising edge
    task automatic step();
        @(posedge axis_clk);
        #10;
    endtask

    task automatic expect_equal(input string what, input data_t got, input data_t exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic axil_write(input addr_t addr, input data_t data);
        logic aw_go;
        logic w_go;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        while (awvalid || wvalid) begin
            aw_go = awvalid && awready;
            w_go  = wvalid && wready;
            step();
            if (aw_go) begin
                awvalid = 1'b0;
            end
            if (w_go) begin
                wvalid = 1'b0;
            end
        end
    endtask

    task automatic axil_read(input addr_t addr, output data_t data);
        logic ar_go;
        ar_go   = 1'b0;
        arvalid = 1'b1;
        araddr  = addr;
        while (!ar_go) begin
            ar_go = arready;
            step();
        end
        arvalid = 1'b0;
        while (!rvalid) begin
            step();
        end
        // response waits one cycle before it is accepted
        step();
        rready = 1'b1;
        data   = rdata;
        step();
        rready = 1'b0;
    endtask

    task automatic send_samples(input int n);
        for (int i = 0; i < n; i++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = samples[i];
            while (!ss_tready) begin
                step();
            end
            step();
            sent++;
        end
        ss_tvalid = 1'b0;
    endtask

    // sm_tready stays low for hold cycles, then is high three times in four
    task automatic collect_results(input int n, input int hold);
        int          got_n;
        int          cyc;
        logic [31:0] r;
        got_n = 0;
        cyc   = 0;
        while (got_n < n) begin
            r = next_rand();
            sm_tready = (cyc >= hold) && (r[31:30] != 2'b00);
            if (sm_tready && sm_tvalid) begin
                expect_equal($sformatf("result %0d", got_n), sm_tdata, expected[got_n]);
                expect_equal($sformatf("tlast of result %0d", got_n),
                             data_t'(sm_tlast), data_t'(got_n == n - 1));
                got_n++;
            end
            step();
            cyc++;
        end
        sm_tready = 1'b0;
    endtask

    task automatic midrun_checks();
        data_t rd;
        wait (sent > 0);
        repeat (6) step();
        axil_read(`FIR_REG_CTRL, rd);
        expect_equal("ctrl start and idle bits during run", rd & 32'h5, 0);
        axil_read(`FIR_REG_TAP_BASE, rd);
        expect_equal("coef 0 read during run", rd, 0);
        // must be dropped, the run keeps its taps
        axil_write(addr_t'(`FIR_REG_TAP_BASE + 4 * 3), ~coef[3]);
    endtask

    task automatic program_run(input int len);
        data_t rd;
        data_t acc;
        for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
            coef[k] = next_rand();
            axil_write(addr_t'(`FIR_REG_TAP_BASE + 4 * k), coef[k]);
        end
        axil_write(`FIR_REG_LEN, len);
        for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
            axil_read(addr_t'(`FIR_REG_TAP_BASE + 4 * k), rd);
            expect_equal($sformatf("coef %0d", k), rd, coef[k]);
        end
        axil_read(`FIR_REG_LEN, rd);
        expect_equal("data length", rd, len);
        for (int n = 0; n < len; n++) begin
            samples[n] = next_rand();
        end
        // reference convolution, samples before the run are zero
        for (int n = 0; n < len; n++) begin
            acc = 0;
            for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
                if (n >= k) begin
                    acc = acc + coef[k] * samples[n - k];
                end
            end
            expected[n] = acc;
        end
    endtask

    task automatic do_run(input int len, input int hold);
        data_t rd;
        sent = 0;
        program_run(len);
        axil_write(`FIR_REG_CTRL, 1);
        fork
            send_samples(len);
            collect_results(len, hold);
            midrun_checks();
        join
        axil_read(`FIR_REG_CTRL, rd);
        expect_equal("ctrl after run", rd, 32'h16);
        axil_read(`FIR_REG_CTRL, rd);
        expect_equal("ctrl after done was read", rd, 32'h14);
        axil_read(addr_t'(`FIR_REG_TAP_BASE + 4 * 3), rd);
        expect_equal("coef 3 after write during run", rd, coef[3]);
        expect_equal("sm_tvalid after run", data_t'(sm_tvalid), 0);
    endtask

    // input side pushed back while the output side is stalled
    always @(negedge axis_clk) begin
        if (axis_rst_n && !ss_tready && !sm_tready) begin
            saw_backpressure = 1'b1;
        end
    end

    initial begin
        data_t rd;
        lcg_state        = 32'he7b810e1;
        errors           = 0;
        checks           = 0;
        sent             = 0;
        saw_backpressure = 1'b0;
        axis_rst_n       = 1'b0;
        awvalid          = 1'b0;
        awaddr           = '0;
        wvalid           = 1'b0;
        wdata            = '0;
        arvalid          = 1'b0;
        araddr           = '0;
        rready           = 1'b0;
        ss_tvalid        = 1'b0;
        ss_tdata         = '0;
        sm_tready        = 1'b0;
        repeat (16) @(posedge axis_clk);
        #10;
        axis_rst_n = 1'b1;
        step();
        axil_read(`FIR_REG_CTRL, rd);
        expect_equal("ctrl after reset", rd, 32'h14);
        expect_equal("sm_tvalid after reset", data_t'(sm_tvalid), 0);
        do_run(RUN1_LEN, STALL_CYCLES);
        do_run(RUN2_LEN, 0);
        checks++;
        assert (saw_backpressure) else begin
            errors++;
            $display("ss_tready never dropped while the output stream was stalled");
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/fir_pkg.sv
fir/word_ram.sv
hdl/stream_fifo.sv
hdl/fir_regs.sv
fir/fir_engine.sv
hdl/fir_top.sv
tests/fir_properties.sv
tests/fir_tb.sv

//--- Makefile
# Verilator build and run of the FIR filter testbench

TOP := fir_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "TEST OK" sim.log; then \
		echo "simulation did not report a pass"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
